// File: list.f
hw/iccm_pkg.sv
hw/iccm_bank_ram.sv
hw/iccm_bank_decode.sv
hw/iccm_redundancy.sv
hw/iccm_read_align.sv
hw/iccm_mem.sv
verif/iccm_clk_gen.sv
verif/iccm_assert.sv
verif/iccm_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= iccm_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/iccm_tb.sv
`timescale 1ns/100ps
`default_nettype none

module iccm_tb;

   localparam int num_banks = 4;
   localparam int n_words   = 1 << (iccm_pkg::ICCM_BITS - 2);

   logic                    clk;
   logic                    arst_n;
   iccm_pkg::iccm_req_t     req;
   iccm_pkg::iccm_rsp_t     rsp;

   // ******************************
   // Reference model
   // ******************************
   iccm_pkg::iccm_word_t    mem_m [n_words];
   iccm_pkg::iccm_waddr_t   row_addr_m [2];
   iccm_pkg::iccm_word_t    row_data_m [2];
   logic [1:0]              row_valid_m;
   logic                    lru_m;

   logic                    rd_pending;   // Response due at the next falling edge
   logic [63:0]             exp_data;
   logic [116:0]            exp_ecc;
   iccm_pkg::iccm_waddr_t   cap [3];

   iccm_clk_gen #(
      .period       (100),
      .reset_cycles (2)
   ) iccm_clk_gen_inst (
      .clk    (clk),
      .arst_n (arst_n)
   );

   iccm_mem #(
      .num_banks (num_banks)
   ) iccm_mem_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (req),
      .rsp    (rsp)
   );

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
      if (got !== exp) begin
         stop_on_error($sformatf("error: time %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   function automatic iccm_pkg::iccm_word_t fill_word(input iccm_pkg::iccm_waddr_t wa);
      return {wa[8:2] ^ 7'h5a, ~wa, 6'h2b ^ wa[7:2], 16'(wa) * 16'h9e37};
   endfunction

   // Row 1 over row 0 over the array
   function automatic iccm_pkg::iccm_word_t model_word(input iccm_pkg::iccm_waddr_t wa);
      return (row_valid_m[1] && row_addr_m[1] == wa) ? row_data_m[1] :
             (row_valid_m[0] && row_addr_m[0] == wa) ? row_data_m[0] : mem_m[wa];
   endfunction

   function automatic iccm_pkg::iccm_req_t make_req(input logic rd, input logic wr, input logic ce,
                                                    input iccm_pkg::iccm_haddr_t a,
                                                    input logic [1:0] size);
      iccm_pkg::iccm_req_t r;
      logic [95:0]         rnd;
      rnd           = {$urandom(), $urandom(), $urandom()};
      r             = '0;
      r.rden        = rd;
      r.wren        = wr;
      r.correct_ecc = ce;
      r.addr        = a;
      r.wr_size     = size;
      r.wr_data     = rnd[77:0];
      return r;
   endfunction

   task automatic predict_read(input iccm_pkg::iccm_haddr_t a);
      iccm_pkg::iccm_haddr_t a_md;
      iccm_pkg::iccm_haddr_t a_hi;
      iccm_pkg::iccm_word_t  lo;
      iccm_pkg::iccm_word_t  md;
      iccm_pkg::iccm_word_t  hi;
      logic [95:0]           data;
      a_md = a + 11'd2;
      a_hi = a + 11'd3;
      lo = model_word(a[11:2]);
      md = model_word(a_md[11:2]);
      hi = model_word(a_hi[11:2]);
      exp_ecc = {hi, md, lo};
      data = {hi[31:0], md[31:0], lo[31:0]};
      if (a[1]) begin
         data = data >> 16;   // Fetch starts on the upper halfword
      end
      exp_data = data[63:0];
   endtask

   task automatic model_update(input iccm_pkg::iccm_req_t r);
      iccm_pkg::iccm_haddr_t a_hi;
      iccm_pkg::iccm_waddr_t wa;
      iccm_pkg::iccm_word_t  w_lo;
      iccm_pkg::iccm_word_t  w_hi;
      logic                  dword;
      logic                  upd;
      a_hi  = r.addr + 11'd3;
      wa    = r.addr[11:2];
      w_lo  = r.wr_data[38:0];
      w_hi  = r.wr_data[77:39];
      dword = (r.wr_size == iccm_pkg::SIZE_DWORD);
      if (r.wren) begin
         mem_m[wa] = wa[2] ? w_hi : w_lo;   // Odd bank takes the high lane
         if (dword) begin
            mem_m[a_hi[11:2]] = a_hi[2] ? w_hi : w_lo;
         end
      end
      for (int k = 0; k < 2; k++) begin
         // Equal word, or a double word whose address differs only in the lowest word bit
         upd = r.wren && row_valid_m[k] &&
               (row_addr_m[k] == wa || (dword && (row_addr_m[k] ^ wa) == 10'd1));
         if (r.correct_ecc && lru_m == 1'(k)) begin
            row_addr_m[k]  = wa;
            row_data_m[k]  = w_lo;
            row_valid_m[k] = 1'b1;
         end else if (upd) begin
            row_data_m[k] = (row_addr_m[k][2] && (dword || wa[2])) ? w_hi : w_lo;
         end
      end
      if (r.correct_ecc) begin
         lru_m = ~lru_m;
      end
   endtask

   // One request per cycle after checking the previous read
   task automatic issue(input iccm_pkg::iccm_req_t r);
      @(negedge clk);
      if (rd_pending) begin
         compare("rsp.rd_data", 128'(rsp.rd_data), 128'(exp_data));
         compare("rsp.rd_data_ecc", 128'(rsp.rd_data_ecc), 128'(exp_ecc));
      end
      req = r;
      rd_pending = r.rden;
      if (r.rden) begin
         predict_read(r.addr);
      end
      model_update(r);
   endtask

   task automatic read_at(input iccm_pkg::iccm_haddr_t a);
      issue(make_req(1'b1, 1'b0, 1'b0, a, 2'b00));
   endtask

   task automatic write_at(input iccm_pkg::iccm_haddr_t a, input logic [1:0] size);
      issue(make_req(1'b0, 1'b1, 1'b0, a, size));
   endtask

   task automatic correct_at(input iccm_pkg::iccm_waddr_t wa);
      issue(make_req(1'b0, 1'b0, 1'b1, {wa, 1'($urandom())}, 2'b00));
   endtask

   // All fetch windows that cover word wa
   task automatic read_window(input iccm_pkg::iccm_waddr_t wa);
      read_at({wa, 1'b0});
      read_at({wa, 1'b1});
      read_at({wa - 10'd1, 1'b0});
      read_at({wa - 10'd1, 1'b1});
      read_at({wa - 10'd2, 1'b1});
   endtask

   task automatic random_op(input logic with_correction);
      int unsigned           kind;
      iccm_pkg::iccm_haddr_t a;
      kind = $urandom_range(0, 9);
      a    = 11'($urandom());
      if (kind < 4) begin
         read_at(a);
      end else if (kind < 7) begin
         write_at(a, 2'b10);
      end else if (kind < 9) begin
         write_at(a, iccm_pkg::SIZE_DWORD);
      end else if (with_correction) begin
         correct_at(a[11:2]);
      end else begin
         read_at(a);
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (arst_n !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > 20) begin
            stop_on_error("timeout: reset was not released within 20 cycles");
         end
      end
   endtask

   initial begin
      iccm_pkg::iccm_req_t r;
      req         = '0;
      rd_pending  = 1'b0;
      row_valid_m = '0;
      lru_m       = 1'b0;
      void'($urandom(32'h2538));
      wait_reset_release();

      // Fill every word with noise in the other lane
      for (int i = 0; i < n_words; i++) begin
         r = make_req(1'b0, 1'b1, 1'b0, {10'(i), 1'b0}, 2'b10);
         if (r.addr[2]) begin
            r.wr_data[77:39] = fill_word(10'(i));
         end else begin
            r.wr_data[38:0] = fill_word(10'(i));
         end
         issue(r);
      end

      repeat (100) read_at(11'($urandom()));   // No rows captured yet
      repeat (600) random_op(1'b0);

      // Double words across a row and across the top of memory
      write_at({10'h3ff, 1'b0}, iccm_pkg::SIZE_DWORD);
      read_window(10'h000);
      write_at({10'h1fb, 1'b1}, iccm_pkg::SIZE_DWORD);
      read_window(10'h1fd);

      // ******************************
      // Redundant rows
      // ******************************
      cap[0] = 10'($urandom());
      cap[1] = cap[0] + 10'd5;
      cap[2] = cap[0] + 10'd9;
      correct_at(cap[0]);
      read_window(cap[0]);
      correct_at(cap[1]);
      read_window(cap[1]);
      correct_at(cap[2]);   // Evicts the oldest row
      read_window(cap[0]);
      read_window(cap[2]);

      write_at({cap[1], 1'b0}, 2'b10);
      read_window(cap[1]);
      write_at({cap[2] ^ 10'd1, 1'b0}, iccm_pkg::SIZE_DWORD);
      read_window(cap[2]);
      write_at({cap[1], 1'b1}, iccm_pkg::SIZE_DWORD);
      read_window(cap[1]);

      repeat (400) random_op(1'b1);
      issue('0);

      if (iccm_mem_inst.iccm_redundancy_inst.iccm_assert_inst.fail_count == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         $display("RESULT: FAIL");
         $fatal(1, "assertion failures were counted");
      end
   end

endmodule

`default_nettype wire

// File: verif/iccm_assert.sv
`timescale 1ns/100ps
`default_nettype none

module iccm_assert #(
   parameter int num_banks = 4
) (
   input wire logic                   clk,
   input wire logic                   arst_n,
   input wire iccm_pkg::iccm_req_t    req,
   input wire logic [1:0]             row_valid,
   input wire logic                   lru,
   input wire logic [num_banks-1:0]   sel_row0_q,
   input wire logic [num_banks-1:0]   sel_row1_q
);

   int fail_count = 0;   // Read by the testbench at the end

   // A captured row stays valid until reset
   valid_held: assert property (@(posedge clk) disable iff (!arst_n)
      (row_valid & $past(row_valid)) == $past(row_valid))
      else begin
         fail_count++;
         $error("redundant row valid fell");
      end

   lru_flip: assert property (@(posedge clk) disable iff (!arst_n)
      (lru != $past(lru)) == $past(req.correct_ecc))
      else begin
         fail_count++;
         $error("LRU bit out of step with correct_ecc");
      end

   // No substitution without a read
   sel_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !req.rden |=> (sel_row0_q == '0) && (sel_row1_q == '0))
      else begin
         fail_count++;
         $error("substitution select set after a cycle without rden");
      end

endmodule

bind iccm_redundancy iccm_assert #(
   .num_banks (num_banks)
) iccm_assert_inst (
   .clk        (clk),
   .arst_n     (arst_n),
   .req        (req),
   .row_valid  (row_valid),
   .lru        (lru),
   .sel_row0_q (sel_row0_q),
   .sel_row1_q (sel_row1_q)
);

`default_nettype wire

// File: verif/iccm_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module iccm_clk_gen #(
   parameter int period       = 100,
   parameter int reset_cycles = 2
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // Release on a falling edge, clear of the sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: hw/iccm_mem.sv
`timescale 1ns/100ps
`default_nettype none

module iccm_mem #(
   parameter int num_banks = 4
) (
   input  wire logic                   clk,
   input  wire logic                   arst_n,
   input  wire iccm_pkg::iccm_req_t    req,
   output iccm_pkg::iccm_rsp_t         rsp
);

   // Words per bank
   localparam int depth = (1 << (iccm_pkg::ICCM_BITS - 2)) / num_banks;
   localparam int row_w = $clog2(depth);

   logic [num_banks-1:0]                  bank_wren;
   logic [num_banks-1:0]                  bank_rden;
   logic [num_banks-1:0][row_w-1:0]       bank_addr;
   iccm_pkg::iccm_word_t [num_banks-1:0]  bank_wdata;
   iccm_pkg::iccm_word_t [num_banks-1:0]  bank_dout;
   logic [num_banks-1:0]                  sel_row0_q;
   logic [num_banks-1:0]                  sel_row1_q;
   iccm_pkg::iccm_word_t                  row0_data;
   iccm_pkg::iccm_word_t                  row1_data;

   // ******************************
   // Banks
   // ******************************

   iccm_bank_decode #(
      .num_banks (num_banks)
   ) iccm_bank_decode_inst (
      .req        (req),
      .bank_wren  (bank_wren),
      .bank_rden  (bank_rden),
      .bank_addr  (bank_addr),
      .bank_wdata (bank_wdata)
   );

   for (genvar i = 0; i < num_banks; i++) begin : g_bank
      iccm_bank_ram #(
         .depth (depth)
      ) iccm_bank_ram_inst (
         .clk (clk),
         .me  (bank_wren[i] | bank_rden[i]),
         .we  (bank_wren[i]),
         .adr (bank_addr[i]),
         .d   (bank_wdata[i]),
         .q   (bank_dout[i])
      );
   end

   // ******************************
   // Redundancy and read path
   // ******************************

   iccm_redundancy #(
      .num_banks (num_banks)
   ) iccm_redundancy_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .sel_row0_q (sel_row0_q),
      .sel_row1_q (sel_row1_q),
      .row0_data  (row0_data),
      .row1_data  (row1_data)
   );

   iccm_read_align #(
      .num_banks (num_banks)
   ) iccm_read_align_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .req        (req),
      .bank_dout  (bank_dout),
      .sel_row0_q (sel_row0_q),
      .sel_row1_q (sel_row1_q),
      .row0_data  (row0_data),
      .row1_data  (row1_data),
      .rsp        (rsp)
   );

endmodule

`default_nettype wire

// File: hw/iccm_read_align.sv
`timescale 1ns/100ps
`default_nettype none

module iccm_read_align #(
   parameter int num_banks = 4
) (
   input  wire logic                                  clk,
   input  wire logic                                  arst_n,
   input  wire iccm_pkg::iccm_req_t                   req,
   input  wire iccm_pkg::iccm_word_t [num_banks-1:0]  bank_dout,
   input  wire logic [num_banks-1:0]                  sel_row0_q,
   input  wire logic [num_banks-1:0]                  sel_row1_q,
   input  wire iccm_pkg::iccm_word_t                  row0_data,
   input  wire iccm_pkg::iccm_word_t                  row1_data,
   output iccm_pkg::iccm_rsp_t                        rsp
);

   localparam int bank_bits = $clog2(num_banks);
   localparam int row_lsb   = bank_bits + 2;

   iccm_pkg::iccm_haddr_t                 addr_md;
   iccm_pkg::iccm_haddr_t                 addr_hi;
   logic [bank_bits:0]                    ptr_lo_q;   // {bank, halfword bit}
   logic [bank_bits-1:0]                  ptr_md_q;
   logic [bank_bits-1:0]                  ptr_hi_q;
   iccm_pkg::iccm_word_t [num_banks-1:0]  dout_fn;
   iccm_pkg::iccm_word_t                  word_lo;
   iccm_pkg::iccm_word_t                  word_md;
   iccm_pkg::iccm_word_t                  word_hi;
   logic [3*iccm_pkg::DATA_W-1:0]         data_pre;
   logic [3*iccm_pkg::DATA_W-1:0]         data_shift;

   assign addr_md = req.addr + 2'd2;
   assign addr_hi = req.addr + 2'd3;

   // Pointers only move on a read so the output holds
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr_lo_q <= '0;
         ptr_md_q <= '0;
         ptr_hi_q <= '0;
      end else if (req.rden) begin
         ptr_lo_q <= req.addr[row_lsb-1:1];
         ptr_md_q <= addr_md[row_lsb-1:2];
         ptr_hi_q <= addr_hi[row_lsb-1:2];
      end
   end

   // Row 1 over row 0 over bank data
   for (genvar i = 0; i < num_banks; i++) begin : g_sub
      assign dout_fn[i] = sel_row1_q[i] ? row1_data :
                          sel_row0_q[i] ? row0_data :
                                          bank_dout[i];
   end

   assign word_lo = dout_fn[ptr_lo_q[bank_bits:1]];
   assign word_md = dout_fn[ptr_md_q];
   assign word_hi = dout_fn[ptr_hi_q];

   // ******************************
   // Output alignment
   // ******************************

   assign data_pre = {word_hi[iccm_pkg::DATA_W-1:0],
                      word_md[iccm_pkg::DATA_W-1:0],
                      word_lo[iccm_pkg::DATA_W-1:0]};

   assign data_shift = ptr_lo_q[0] ? (data_pre >> 16) : data_pre;   // Odd halfword start

   assign rsp.rd_data     = data_shift[2*iccm_pkg::DATA_W-1:0];
   assign rsp.rd_data_ecc = {word_hi, word_md, word_lo};

endmodule

`default_nettype wire

// File: hw/iccm_redundancy.sv
`timescale 1ns/100ps
`default_nettype none

module iccm_redundancy #(
   parameter int num_banks = 4
) (
   input  wire logic                   clk,
   input  wire logic                   arst_n,
   input  wire iccm_pkg::iccm_req_t    req,
   output logic [num_banks-1:0]        sel_row0_q,
   output logic [num_banks-1:0]        sel_row1_q,
   output iccm_pkg::iccm_word_t        row0_data,
   output iccm_pkg::iccm_word_t        row1_data
);

   localparam int bank_bits = $clog2(num_banks);
   localparam int row_lsb   = bank_bits + 2;

   iccm_pkg::iccm_haddr_t   addr_md;
   iccm_pkg::iccm_haddr_t   addr_hi;
   iccm_pkg::iccm_waddr_t   waddr_lo;
   iccm_pkg::iccm_waddr_t   waddr_md;
   iccm_pkg::iccm_waddr_t   waddr_hi;
   iccm_pkg::iccm_word_t    wr_lo;
   iccm_pkg::iccm_word_t    wr_hi;
   logic                    dword;

   // Two redundant rows and the replacement pointer
   iccm_pkg::iccm_waddr_t   row_addr [2];
   iccm_pkg::iccm_word_t    row_data [2];
   logic [1:0]              row_valid;
   logic                    lru;

   logic [1:0]              capture;
   logic [1:0]              update;
   logic [1:0]              use_high;
   logic [1:0]              hit_lo;
   logic [1:0]              hit_md;
   logic [1:0]              hit_hi;
   logic [1:0][num_banks-1:0] sel_d;

   assign addr_md  = req.addr + 2'd2;
   assign addr_hi  = req.addr + 2'd3;
   assign waddr_lo = req.addr[iccm_pkg::ICCM_BITS-1:2];
   assign waddr_md = addr_md[iccm_pkg::ICCM_BITS-1:2];
   assign waddr_hi = addr_hi[iccm_pkg::ICCM_BITS-1:2];

   assign wr_lo = req.wr_data[iccm_pkg::WORD_W-1:0];
   assign wr_hi = req.wr_data[2*iccm_pkg::WORD_W-1:iccm_pkg::WORD_W];
   assign dword = (req.wr_size == iccm_pkg::SIZE_DWORD);

   // ******************************
   // Row capture and update
   // ******************************

   always_comb begin
      for (int r = 0; r < 2; r++) begin
         capture[r] = req.correct_ecc & (lru == 1'(r));   // LRU picks the victim
         // Same word, or a double word covering the pair
         update[r] = req.wren & row_valid[r] &
                     (waddr_lo[iccm_pkg::ICCM_BITS-1:3] == row_addr[r][iccm_pkg::ICCM_BITS-1:3]) &
                     ((waddr_lo[2] == row_addr[r][2]) | dword);
         use_high[r] = row_addr[r][2] & (dword | waddr_lo[2]);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         row_valid   <= '0;
         row_addr[0] <= '0;
         row_addr[1] <= '0;
         lru         <= 1'b0;
      end else begin
         for (int r = 0; r < 2; r++) begin
            if (capture[r]) begin
               row_valid[r] <= 1'b1;
               row_addr[r]  <= waddr_lo;
            end
         end
         if (req.correct_ecc) begin
            lru <= ~lru;
         end
      end
   end

   // Capture wins over a write update in the same cycle
   always_ff @(posedge clk) begin
      for (int r = 0; r < 2; r++) begin
         if (capture[r]) begin
            row_data[r] <= wr_lo;
         end else if (update[r]) begin
            row_data[r] <= use_high[r] ? wr_hi : wr_lo;
         end
      end
   end

   assign row0_data = row_data[0];
   assign row1_data = row_data[1];

   // ******************************
   // Read substitution selects
   // ******************************

   always_comb begin
      for (int r = 0; r < 2; r++) begin
         hit_lo[r] = row_valid[r] & (waddr_lo == row_addr[r]);
         hit_md[r] = row_valid[r] & (waddr_md == row_addr[r]);
         hit_hi[r] = row_valid[r] & (waddr_hi == row_addr[r]);
         for (int i = 0; i < num_banks; i++) begin
            sel_d[r][i] = req.rden &
                          ((hit_lo[r] & (req.addr[row_lsb-1:2] == bank_bits'(i))) |
                           (hit_md[r] & (addr_md[row_lsb-1:2] == bank_bits'(i))) |
                           (hit_hi[r] & (addr_hi[row_lsb-1:2] == bank_bits'(i))));
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sel_row0_q <= '0;
         sel_row1_q <= '0;
      end else begin
         sel_row0_q <= sel_d[0];   // Aligned with bank Q
         sel_row1_q <= sel_d[1];
      end
   end

endmodule

`default_nettype wire

// File: hw/iccm_bank_decode.sv
`timescale 1ns/100ps
`default_nettype none

module iccm_bank_decode #(
   parameter  int num_banks = 4,
   localparam int row_w     = iccm_pkg::ICCM_BITS - 2 - $clog2(num_banks)
) (
   input  wire iccm_pkg::iccm_req_t                  req,
   output logic [num_banks-1:0]                      bank_wren,
   output logic [num_banks-1:0]                      bank_rden,
   output logic [num_banks-1:0][row_w-1:0]           bank_addr,
   output iccm_pkg::iccm_word_t [num_banks-1:0]      bank_wdata
);

   localparam int bank_bits = $clog2(num_banks);
   localparam int row_lsb   = bank_bits + 2;

   iccm_pkg::iccm_haddr_t   addr_md;
   iccm_pkg::iccm_haddr_t   addr_hi;
   logic [bank_bits-1:0]    bank_lo;
   logic [bank_bits-1:0]    bank_md;
   logic [bank_bits-1:0]    bank_hi;
   logic [row_w-1:0]        row_lo;
   logic [row_w-1:0]        row_md;
   logic [row_w-1:0]        row_hi;
   logic                    dword;

   // ******************************
   // Read window
   // ******************************

   // Middle and high words of the fetch, may wrap into the next row
   assign addr_md = req.addr + 2'd2;
   assign addr_hi = req.addr + 2'd3;

   assign bank_lo = req.addr[row_lsb-1:2];
   assign bank_md = addr_md[row_lsb-1:2];
   assign bank_hi = addr_hi[row_lsb-1:2];

   assign row_lo = req.addr[iccm_pkg::ICCM_BITS-1:row_lsb];
   assign row_md = addr_md[iccm_pkg::ICCM_BITS-1:row_lsb];
   assign row_hi = addr_hi[iccm_pkg::ICCM_BITS-1:row_lsb];

   assign dword = (req.wr_size == iccm_pkg::SIZE_DWORD);

   // ******************************
   // Per-bank controls
   // ******************************

   for (genvar i = 0; i < num_banks; i++) begin : g_bank
      logic wr_lo;   // Bank holds the base word of a write

      assign wr_lo = req.wren & (bank_lo == bank_bits'(i));

      assign bank_wren[i] = wr_lo | (req.wren & dword & (bank_hi == bank_bits'(i)));

      assign bank_rden[i] = req.rden & ((bank_lo == bank_bits'(i)) |
                                        (bank_md == bank_bits'(i)) |
                                        (bank_hi == bank_bits'(i)));

      // Write target first, then high, middle, base
      assign bank_addr[i] = wr_lo                       ? row_lo :
                            (bank_hi == bank_bits'(i))  ? row_hi :
                            (bank_md == bank_bits'(i))  ? row_md :
                                                          row_lo;

      // Even banks take the low lane, odd banks the high lane
      assign bank_wdata[i] = (i % 2 == 1) ?
                             req.wr_data[2*iccm_pkg::WORD_W-1:iccm_pkg::WORD_W] :
                             req.wr_data[iccm_pkg::WORD_W-1:0];
   end

endmodule

`default_nettype wire

// File: hw/iccm_bank_ram.sv
`timescale 1ns/100ps
`default_nettype none

module iccm_bank_ram #(
   parameter int depth = 256
) (
   input  wire logic                       clk,
   input  wire logic                       me,
   input  wire logic                       we,
   input  wire logic [$clog2(depth)-1:0]   adr,
   input  wire iccm_pkg::iccm_word_t       d,
   output iccm_pkg::iccm_word_t            q
);

   iccm_pkg::iccm_word_t mem [depth];

   // Single port, write has no read-through
   always_ff @(posedge clk) begin
      if (me) begin
         if (we) begin
            mem[adr] <= d;
         end else begin
            q <= mem[adr];   // Q holds while me is low
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/iccm_pkg.sv
`default_nettype none

package iccm_pkg;

   // ******************************
   // Sizes
   // ******************************

   localparam int ICCM_BITS = 12;   // Byte address bits, 4 KiB
   localparam int WORD_W    = 39;   // 32 data + 7 check
   localparam int DATA_W    = 32;

   // Write size code for a double-word store
   localparam logic [1:0] SIZE_DWORD = 2'b11;

   // ******************************
   // Address and word types
   // ******************************

   typedef logic [WORD_W-1:0]    iccm_word_t;
   typedef logic [ICCM_BITS-1:1] iccm_haddr_t;   // Halfword address
   typedef logic [ICCM_BITS-1:2] iccm_waddr_t;   // Word address

   // ******************************
   // Request and response
   // ******************************

   typedef struct packed {
      logic                  rden;
      logic                  wren;
      logic                  correct_ecc;   // Capture into a redundant row
      iccm_haddr_t           addr;
      logic [1:0]            wr_size;
      logic [2*WORD_W-1:0]   wr_data;       // {high word, low word}
   } iccm_req_t;

   typedef struct packed {
      logic [2*DATA_W-1:0]   rd_data;
      logic [3*WORD_W-1:0]   rd_data_ecc;   // {high, middle, low}
   } iccm_rsp_t;

endpackage

`default_nettype wire
